// File: Bender.yml
package:
  name: move_sort

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/move_sort_pkg.sv
      - logic/move_ram.sv
      - logic/move_loader.sv
      - logic/move_sort.sv
      - logic/move_sort_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clock_gen.sv
      - testbench/move_sort_assertions.sv
      - testbench/move_sort_tb.sv

// File: include/move_sort_defines.svh
/* Move list sizing */

`ifndef MOVE_SORT_DEFINES_SVH
`define MOVE_SORT_DEFINES_SVH

// Number of list entries as a power of two
`define MOVE_MAX_POSITIONS 64

// Bits needed to address one entry
`define MOVE_IDX_WIDTH ($clog2(`MOVE_MAX_POSITIONS))

// Signed evaluation in centipawns
`define MOVE_EVAL_WIDTH 16

// 64 board squares
`define MOVE_SQUARE_WIDTH 6

`endif

// File: logic/move_loader.sv
/* Host move loader */

`timescale 1ns/1ps

`include "move_sort_defines.svh"

module move_loader (
   input  logic                     clk,
   input  logic                     reset,

   input  logic                     move_valid,
   input  move_sort_pkg::move_rec_t move_in,
   input  logic                     move_clear,
   input  logic                     busy,
   output logic                     move_ready,

   output logic                     wr_en,
   output move_sort_pkg::move_idx_t wr_addr,
   output move_sort_pkg::move_rec_t wr_data,
   output move_sort_pkg::move_cnt_t list_len
);

   move_sort_pkg::move_idx_t wr_idx;
   move_sort_pkg::move_cnt_t count;
   logic                     full;

   assign full = (count == move_sort_pkg::move_cnt_t'(`MOVE_MAX_POSITIONS));

   // No writes while sorting or once the list is full
   assign move_ready = ~busy & ~full;

   assign wr_en    = move_valid & move_ready;
   assign wr_addr  = wr_idx;
   assign wr_data  = move_in;
   assign list_len = count;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_idx <= '0;
         count  <= '0;
      end
      else if (move_clear)
      begin
         wr_idx <= '0;
         count  <= '0;
      end
      else if (wr_en)
      begin
         wr_idx <= wr_idx + 1'b1;
         count  <= count + 1'b1;
      end
   end

endmodule

// File: logic/move_ram.sv
/* Dual-port move record RAM */

`timescale 1ns/1ps

`include "move_sort_defines.svh"

module move_ram (
   input  logic                    clk,

   input  logic                    a_en,
   input  logic                    a_wr,
   input  move_sort_pkg::move_idx_t a_addr,
   input  move_sort_pkg::move_rec_t a_wdata,
   output move_sort_pkg::move_rec_t a_rdata,

   input  logic                    b_en,
   input  logic                    b_wr,
   input  move_sort_pkg::move_idx_t b_addr,
   input  move_sort_pkg::move_rec_t b_wdata,
   output move_sort_pkg::move_rec_t b_rdata
);

   move_sort_pkg::move_rec_t mem [`MOVE_MAX_POSITIONS];

   // Read-first on both ports
   always_ff @(posedge clk)
   begin
      if (a_en)
      begin
         a_rdata <= mem[a_addr];
         if (a_wr)
            mem[a_addr] <= a_wdata;
      end
      if (b_en)
      begin
         b_rdata <= mem[b_addr];
         if (b_wr)
            mem[b_addr] <= b_wdata;
      end
   end

endmodule

// File: logic/move_sort.sv
/* In-place bubble sort of the move list */

`timescale 1ns/1ps

module move_sort (
   input  logic                     clk,
   input  logic                     reset,

   input  logic                     sort_start,
   input  logic                     sort_clear,
   input  logic                     white_to_move,
   input  move_sort_pkg::move_cnt_t list_len,

   input  logic                     wr_en,
   input  move_sort_pkg::move_idx_t wr_addr,
   input  move_sort_pkg::move_rec_t wr_data,

   input  move_sort_pkg::move_idx_t rd_addr,
   output move_sort_pkg::move_rec_t rd_data,

   output logic                     busy,
   output logic                     sort_complete
);

   move_sort_pkg::sort_state_t state;

   logic                       start_q;
   logic                       start_rise;
   logic                       host_io;
   logic                       swap_pair;

   // Pair under test is (pos, pos + 1)
   move_sort_pkg::move_idx_t   pos;
   move_sort_pkg::move_idx_t   pos_hi;
   move_sort_pkg::move_cnt_t   last;
   move_sort_pkg::move_cnt_t   last_swap;

   move_sort_pkg::eval_t       eval_a;
   move_sort_pkg::eval_t       eval_b;
   logic                       pv_a;
   logic                       pv_b;

   logic                       a_en;
   logic                       a_wr;
   move_sort_pkg::move_idx_t   a_addr;
   move_sort_pkg::move_rec_t   a_wdata;
   move_sort_pkg::move_rec_t   a_rdata;
   logic                       b_en;
   logic                       b_wr;
   move_sort_pkg::move_idx_t   b_addr;
   move_sort_pkg::move_rec_t   b_wdata;
   move_sort_pkg::move_rec_t   b_rdata;

   always_ff @(posedge clk)
   begin
      if (reset)
         start_q <= 1'b0;
      else
         start_q <= sort_start;
   end

   assign start_rise = sort_start & ~start_q & (state == move_sort_pkg::idle);

   // Host owns the RAM whenever no pass is in progress
   assign host_io = (state == move_sort_pkg::idle) || (state == move_sort_pkg::done);

   // Busy already in the start cycle so no write slips past list_len
   assign busy          = (state != move_sort_pkg::idle) | start_rise;
   assign sort_complete = (state == move_sort_pkg::done);

   assign pos_hi = pos + 1'b1;

   assign eval_a = a_rdata.eval;
   assign eval_b = b_rdata.eval;
   assign pv_a   = a_rdata.pv;
   assign pv_b   = b_rdata.pv;

   // Swap only when the lower entry must strictly follow the upper one
   always_comb
   begin
      if (pv_a != pv_b)
         swap_pair = pv_b;
      else if (white_to_move)
         swap_pair = (eval_a < eval_b);
      else
         swap_pair = (eval_a > eval_b);
   end

   // Port A writes, port B reads for the host
   always_comb
   begin
      if (host_io)
      begin
         a_en    = wr_en;
         a_wr    = wr_en;
         a_addr  = wr_addr;
         a_wdata = wr_data;
         b_en    = 1'b1;
         b_wr    = 1'b0;
         b_addr  = rd_addr;
         b_wdata = '0;
      end
      else
      begin
         a_en    = 1'b1;
         a_wr    = (state == move_sort_pkg::swap);
         a_addr  = pos;
         a_wdata = b_rdata;
         b_en    = 1'b1;
         b_wr    = (state == move_sort_pkg::swap);
         b_addr  = pos_hi;
         b_wdata = a_rdata;
      end
   end

   assign rd_data = b_rdata;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= move_sort_pkg::idle;
         pos       <= '0;
         last      <= '0;
         last_swap <= '0;
      end
      else
      begin
         unique case (state)
            move_sort_pkg::idle:
            begin
               last <= list_len;
               if (start_rise)
               begin
                  if (list_len <= 1)
                     state <= move_sort_pkg::done;
                  else
                     state <= move_sort_pkg::outer_init;
               end
            end
            move_sort_pkg::outer_init:
            begin
               pos       <= '0;
               last_swap <= '0;
               state     <= move_sort_pkg::read_wait0;
            end
            move_sort_pkg::read_wait0:
               state <= move_sort_pkg::read_wait1;
            move_sort_pkg::read_wait1:
               state <= move_sort_pkg::compare;
            move_sort_pkg::compare:
            begin
               if (swap_pair)
                  state <= move_sort_pkg::swap;
               else
                  state <= move_sort_pkg::inner;
            end
            move_sort_pkg::swap:
            begin
               // Everything above the last swap is already in place
               last_swap <= move_sort_pkg::move_cnt_t'(pos_hi);
               state     <= move_sort_pkg::inner;
            end
            move_sort_pkg::inner:
            begin
               pos <= pos + 1'b1;
               if (move_sort_pkg::move_cnt_t'(pos_hi) == last - 1'b1)
                  state <= move_sort_pkg::outer_test;
               else
                  state <= move_sort_pkg::read_wait0;
            end
            move_sort_pkg::outer_test:
            begin
               last <= last_swap;
               if (last_swap > 1)
                  state <= move_sort_pkg::outer_init;
               else
                  state <= move_sort_pkg::done;
            end
            move_sort_pkg::done:
            begin
               if (sort_clear)
                  state <= move_sort_pkg::idle;
            end
            default:
               state <= move_sort_pkg::idle;
         endcase
      end
   end

   move_ram u_move_ram (
      .clk     (clk),
      .a_en    (a_en),
      .a_wr    (a_wr),
      .a_addr  (a_addr),
      .a_wdata (a_wdata),
      .a_rdata (a_rdata),
      .b_en    (b_en),
      .b_wr    (b_wr),
      .b_addr  (b_addr),
      .b_wdata (b_wdata),
      .b_rdata (b_rdata)
   );

endmodule

// File: logic/move_sort_pkg.sv
/* Move list types */

`include "move_sort_defines.svh"

package move_sort_pkg;

   // Entry index and a fill count wide enough for a full list
   typedef logic [`MOVE_IDX_WIDTH-1:0] move_idx_t;
   typedef logic [`MOVE_IDX_WIDTH:0]   move_cnt_t;

   typedef logic signed [`MOVE_EVAL_WIDTH-1:0] eval_t;
   typedef logic [`MOVE_SQUARE_WIDTH-1:0]      square_t;

   // One stored move with the pv flag in the top bit
   typedef struct packed {
      logic    pv;
      square_t from_sq;
      square_t to_sq;
      eval_t   eval;
   } move_rec_t;

   // Bubble sort sequencer
   typedef enum logic [3:0] {
      idle,
      outer_init,
      read_wait0,
      read_wait1,
      compare,
      swap,
      inner,
      outer_test,
      done
   } sort_state_t;

endpackage

// File: logic/move_sort_top.sv
/* Move list sorter top level */

`timescale 1ns/1ps

module move_sort_top (
   input  logic                     clk,
   input  logic                     reset,

   input  logic                     move_valid,
   input  move_sort_pkg::move_rec_t move_in,
   output logic                     move_ready,
   input  logic                     move_clear,

   input  logic                     sort_start,
   input  logic                     sort_clear,
   input  logic                     white_to_move,

   input  move_sort_pkg::move_idx_t rd_addr,
   output move_sort_pkg::move_rec_t rd_data,

   output logic                     sort_complete,
   output move_sort_pkg::move_cnt_t list_len
);

   logic                     busy;
   logic                     wr_en;
   move_sort_pkg::move_idx_t wr_addr;
   move_sort_pkg::move_rec_t wr_data;

   move_loader u_move_loader (
      .clk        (clk),
      .reset      (reset),
      .move_valid (move_valid),
      .move_in    (move_in),
      .move_clear (move_clear),
      .busy       (busy),
      .move_ready (move_ready),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .list_len   (list_len)
   );

   move_sort u_move_sort (
      .clk           (clk),
      .reset         (reset),
      .sort_start    (sort_start),
      .sort_clear    (sort_clear),
      .white_to_move (white_to_move),
      .list_len      (list_len),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .busy          (busy),
      .sort_complete (sort_complete)
   );

endmodule

// File: sources.f
+incdir+include
logic/move_sort_pkg.sv
logic/move_ram.sv
logic/move_loader.sv
logic/move_sort.sv
logic/move_sort_top.sv
testbench/tb_clock_gen.sv
testbench/move_sort_assertions.sv
testbench/move_sort_tb.sv

// File: testbench/move_sort_assertions.sv
/* Sorter handshake assertions */

`timescale 1ns/1ps

module move_sort_assertions (
   input logic                       clk,
   input logic                       reset,
   input logic                       wr_en,
   input logic                       busy,
   input logic                       sort_clear,
   input logic                       sort_complete,
   input move_sort_pkg::sort_state_t state
);

   int failures = 0;

   // Host writes reach port A only between sorts
   no_write_while_busy: assert property (@(posedge clk) disable iff (reset)
      wr_en |-> !busy)
   else
   begin
      failures++;
      $error("host write accepted while the sorter is busy");
   end

   // Done lasts until the host clears it
   complete_held_in_done: assert property (@(posedge clk) disable iff (reset)
      sort_complete && !sort_clear |=> (state == move_sort_pkg::done))
   else
   begin
      failures++;
      $error("done state left without a sort_clear");
   end

   // Only a clear leaves done
   busy_falls_on_clear: assert property (@(posedge clk) disable iff (reset)
      $fell(busy) |-> $past(sort_clear))
   else
   begin
      failures++;
      $error("busy fell without a preceding sort_clear");
   end

endmodule

bind move_sort move_sort_assertions u_move_sort_assertions (
   .clk           (clk),
   .reset         (reset),
   .wr_en         (wr_en),
   .busy          (busy),
   .sort_clear    (sort_clear),
   .sort_complete (sort_complete),
   .state         (state)
);

// File: testbench/move_sort_tb.sv
/* Move list sorter testbench */

`timescale 1ns/1ps

`include "move_sort_defines.svh"

module move_sort_tb;

   localparam int TIMEOUT = 100000;

   logic                     clk;
   logic                     reset;
   logic                     move_valid;
   move_sort_pkg::move_rec_t move_in;
   logic                     move_ready;
   logic                     move_clear;
   logic                     sort_start;
   logic                     sort_clear;
   logic                     white_to_move;
   move_sort_pkg::move_idx_t rd_addr;
   move_sort_pkg::move_rec_t rd_data;
   logic                     sort_complete;
   move_sort_pkg::move_cnt_t list_len;

   // Expected list contents in index order
   move_sort_pkg::move_rec_t exp_q[$];

   integer seed = 32'hf01b_584f;
   int     errors;
   int     timeouts;
   int     checks;
   int     fail_base;
   int     assert_fails;

   tb_clock_gen u_tb_clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   move_sort_top u_move_sort_top (
      .clk           (clk),
      .reset         (reset),
      .move_valid    (move_valid),
      .move_in       (move_in),
      .move_ready    (move_ready),
      .move_clear    (move_clear),
      .sort_start    (sort_start),
      .sort_clear    (sort_clear),
      .white_to_move (white_to_move),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .sort_complete (sort_complete),
      .list_len      (list_len)
   );

   function automatic move_sort_pkg::move_rec_t random_move(input bit narrow);
      move_sort_pkg::move_rec_t r;
      r.pv      = (($random(seed) & 7) == 0);
      r.from_sq = move_sort_pkg::square_t'($random(seed));
      r.to_sq   = move_sort_pkg::square_t'($random(seed));
      // Narrow range gives plenty of equal evaluations
      if (narrow)
         r.eval = move_sort_pkg::eval_t'(($random(seed) % 5) * 40);
      else
         r.eval = move_sort_pkg::eval_t'($random(seed));
      return r;
   endfunction

   // True when e has to sit after x
   function automatic bit must_follow(input move_sort_pkg::move_rec_t e,
                                      input move_sort_pkg::move_rec_t x, input bit white);
      if (e.pv != x.pv)
         return x.pv;
      if (white)
         return e.eval < x.eval;
      return e.eval > x.eval;
   endfunction

   // Stable insertion sort of the expected list
   task automatic sort_model(input bit white);
      move_sort_pkg::move_rec_t key;
      int                       j;
      for (int i = 1; i < exp_q.size(); i++)
      begin
         key = exp_q[i];
         j   = i - 1;
         while (j >= 0 && must_follow(exp_q[j], key, white))
         begin
            exp_q[j+1] = exp_q[j];
            j--;
         end
         exp_q[j+1] = key;
      end
   endtask

   task automatic check_value(input string what, input int got, input int exp);
      checks++;
      assert (got == exp)
      else
      begin
         errors++;
         $display("ERR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      @(negedge clk);
      while (!move_ready && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (!move_ready)
      begin
         timeouts++;
         $display("Timed out at %0t waiting for move_ready to rise", $time);
      end
   endtask

   task automatic wait_complete();
      int n;
      n = 0;
      @(negedge clk);
      while (!sort_complete && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (!sort_complete)
      begin
         timeouts++;
         $display("Timed out at %0t waiting for the sort to complete", $time);
      end
   endtask

   task automatic write_move(input move_sort_pkg::move_rec_t rec);
      @(posedge clk);
      #1 move_valid = 1'b1;
      move_in = rec;
      wait_ready();
      @(posedge clk);
      #1 move_valid = 1'b0;
      exp_q.push_back(rec);
   endtask

   task automatic load_list(input int n, input bit narrow);
      for (int i = 0; i < n; i++)
         write_move(random_move(narrow));
   endtask

   task automatic clear_list();
      @(posedge clk);
      #1 move_clear = 1'b1;
      @(posedge clk);
      #1 move_clear = 1'b0;
      exp_q.delete();
   endtask

   task automatic pulse_start(input bit white);
      white_to_move = white;
      @(posedge clk);
      #1 sort_start = 1'b1;
      @(posedge clk);
      #1 sort_start = 1'b0;
   endtask

   task automatic pulse_sort_clear();
      @(posedge clk);
      #1 sort_clear = 1'b1;
      @(posedge clk);
      #1 sort_clear = 1'b0;
   endtask

   task automatic run_sort(input bit white);
      pulse_start(white);
      wait_complete();
   endtask

   task automatic end_sort();
      pulse_sort_clear();
      @(negedge clk);
      check_value("sort_complete after clear", sort_complete, 0);
   endtask

   task automatic read_entry(input int idx, output move_sort_pkg::move_rec_t rec);
      @(posedge clk);
      #1 rd_addr = move_sort_pkg::move_idx_t'(idx);
      @(posedge clk);
      #1 rec = rd_data;
   endtask

   task automatic check_list();
      move_sort_pkg::move_rec_t got;
      for (int i = 0; i < exp_q.size(); i++)
      begin
         read_entry(i, got);
         checks++;
         assert (got === exp_q[i])
         else
         begin
            errors++;
            $display("ERR at %0t: entry %0d reads %h, expected %h", $time, i, got, exp_q[i]);
         end
      end
   endtask

   task automatic check_len(input int exp);
      @(negedge clk);
      check_value("list_len", list_len, exp);
   endtask

   task automatic report_test(input int num, input string name);
      $display("Test %0d %s finished, %0d failures", num, name,
               errors + timeouts - fail_base);
      fail_base = errors + timeouts;
   endtask

   task automatic test_load_readback();
      @(negedge clk);
      check_value("sort_complete after reset", sort_complete, 0);
      check_value("move_ready after reset", move_ready, 1);
      check_len(0);
      load_list(20, 1'b0);
      check_len(20);
      check_list();
      report_test(1, "load and read back");
   endtask

   task automatic test_sort(input int num, input bit white);
      clear_list();
      load_list(40, 1'b1);
      run_sort(white);
      sort_model(white);
      check_list();
      end_sort();
      report_test(num, white ? "white sort" : "black sort");
   endtask

   task automatic test_trivial();
      clear_list();
      run_sort(1'b1);
      end_sort();
      write_move(random_move(1'b0));
      run_sort(1'b0);
      check_list();
      end_sort();
      report_test(4, "trivial lists");
   endtask

   task automatic test_capacity();
      move_sort_pkg::move_rec_t first;
      clear_list();
      load_list(`MOVE_MAX_POSITIONS, 1'b0);
      // Six more attempts against a full list
      @(posedge clk);
      #1 move_valid = 1'b1;
      move_in = random_move(1'b0);
      repeat (6)
      begin
         @(negedge clk);
         check_value("move_ready with a full list", move_ready, 0);
      end
      @(posedge clk);
      #1 move_valid = 1'b0;
      check_len(`MOVE_MAX_POSITIONS);
      clear_list();
      check_len(0);
      first = random_move(1'b0);
      write_move(first);
      check_len(1);
      check_list();
      report_test(5, "capacity and clear");
   endtask

   task automatic test_write_during_sort();
      move_sort_pkg::move_rec_t held;
      int                       n;
      clear_list();
      load_list(10, 1'b1);
      held = random_move(1'b1);
      white_to_move = 1'b1;
      @(posedge clk);
      #1 sort_start = 1'b1;
      move_valid = 1'b1;
      move_in = held;
      @(posedge clk);
      #1 sort_start = 1'b0;
      n = 0;
      @(negedge clk);
      while (!sort_complete && n < TIMEOUT)
      begin
         check_value("move_ready during sort", move_ready, 0);
         @(negedge clk);
         n++;
      end
      if (!sort_complete)
      begin
         timeouts++;
         $display("Timed out at %0t waiting for the sort with a held write", $time);
      end
      check_len(10);
      pulse_sort_clear();
      wait_ready();
      @(posedge clk);
      #1 move_valid = 1'b0;
      check_len(11);
      sort_model(1'b1);
      exp_q.push_back(held);
      check_list();
      report_test(6, "writes during a sort");
   endtask

   initial
   begin
      int n;
      move_valid    = 1'b0;
      move_in       = '0;
      move_clear    = 1'b0;
      sort_start    = 1'b0;
      sort_clear    = 1'b0;
      white_to_move = 1'b1;
      rd_addr       = '0;
      errors        = 0;
      timeouts      = 0;
      checks        = 0;
      fail_base     = 0;
      assert_fails  = 0;
      n             = 0;
      @(posedge clk);
      while (reset && n < 100)
      begin
         @(posedge clk);
         n++;
      end
      if (reset)
      begin
         timeouts++;
         $display("Reset never released");
      end
      test_load_readback();
      test_sort(2, 1'b1);
      test_sort(3, 1'b0);
      test_trivial();
      test_capacity();
      test_write_during_sort();
      assert_fails = u_move_sort_top.u_move_sort.u_move_sort_assertions.failures;
      $display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
               checks, errors, timeouts, assert_fails);
      if (errors == 0 && timeouts == 0 && assert_fails == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: testbench/tb_clock_gen.sv
/* Testbench clock and reset */

`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic reset
);

   // 100 ns period
   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule
